//--- Makefile
TOP := awe_row_buffers_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)

# the log decides the result, the simulator status is not used
run: build
	-./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1
	@cat sim.log
	@! grep -q "Testbench failed" sim.log
	@grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- design/awe_config.svh
`ifndef AWE_CONFIG_SVH
`define AWE_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// data path widths
//////////////////////////////////////////////////////////////////////

// bits per pixel
`define AWE_PIXEL_WIDTH 16
// column index bits, one row per RAM half
`define AWE_COL_WIDTH 5

//////////////////////////////////////////////////////////////////////
// pipeline timing
//////////////////////////////////////////////////////////////////////

// RAM read enable to data
`define AWE_RAM_READ_LATENCY 2
// registered read enable to valid strobe
`define AWE_VALID_DELAY 3
// valid cycles per 3x3 window
`define AWE_WINDOW_CYCLES 5

`endif

//--- design/awe_ctrl_pkg.sv
package awe_ctrl_pkg;

    // one-hot job phase driven by the AWE controller
    typedef enum logic [5:0] {
        idle          = 6'b000001,
        prim_buffer   = 6'b000010,
        wait_pfb_load = 6'b000100,
        ce_active     = 6'b001000,
        wait_job_done = 6'b010000,
        send_complete = 6'b100000
    } awe_phase_t;

    typedef logic [2:0] window_cnt_t;

    // row rotation code, bit 1 flips the even half and bit 0 the odd half
    typedef logic [1:0] gray_code_t;

endpackage

//--- design/awe_data_pkg.sv
`include "awe_config.svh"

package awe_data_pkg;

    typedef logic [`AWE_PIXEL_WIDTH-1:0] pixel_t;
    // odd bank pixel sits in the upper half
    typedef logic [2*`AWE_PIXEL_WIDTH-1:0] pixel_pair_t;
    typedef logic [`AWE_COL_WIDTH-1:0] col_idx_t;
    typedef logic [1:0] row_idx_t;
    // half bit on top selects the row held in the RAM
    typedef logic [`AWE_COL_WIDTH:0] bank_addr_t;
    typedef logic [2*`AWE_COL_WIDTH:0] seq_word_t;

    // sequence word fields
    localparam int seq_flip_bit = 2 * `AWE_COL_WIDTH;
    localparam int seq_odd_lsb = `AWE_COL_WIDTH;

endpackage

//--- design/awe_row_buffers.sv
`timescale 1ns/1ns

module awe_row_buffers (
    input  logic                       clk,
    input  logic                       rst,
    input  awe_ctrl_pkg::awe_phase_t   phase,
    input  awe_ctrl_pkg::gray_code_t   gray_code,
    input  logic                       pfb_rden,
    input  awe_data_pkg::row_idx_t     input_row,
    input  awe_data_pkg::col_idx_t     input_col,
    input  awe_data_pkg::col_idx_t     num_cols,
    input  awe_data_pkg::seq_word_t    seq_datain,
    input  awe_data_pkg::pixel_t       ce0_pixel_datain,
    input  awe_data_pkg::pixel_t       ce1_pixel_datain,
    input  logic                       ce0_execute,
    input  logic                       ce1_execute,
    output awe_data_pkg::pixel_pair_t  ce0_pixel_dataout,
    output logic                       ce0_pixel_dataout_valid,
    output awe_ctrl_pkg::window_cnt_t  ce0_cycle_counter,
    output awe_data_pkg::pixel_pair_t  ce1_pixel_dataout,
    output logic                       ce1_pixel_dataout_valid,
    output awe_ctrl_pkg::window_cnt_t  ce1_cycle_counter
);
    import awe_data_pkg::*;

    bank_addr_t even_addr;
    bank_addr_t odd_addr;
    bank_addr_t even_addr_d;
    bank_addr_t odd_addr_d;

    pix_seq_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .seq_datain  (seq_datain),
        .gray_code   (gray_code),
        .even_addr   (even_addr),
        .odd_addr    (odd_addr),
        .even_addr_d (even_addr_d),
        .odd_addr_d  (odd_addr_d)
    );

    //////////////////////////////////////////////////////////////////////
    // engine 0 on the live word, engine 1 on the word one cycle back
    //////////////////////////////////////////////////////////////////////

    ce_row_buffer u_ce0 (
        .clk                 (clk),
        .rst                 (rst),
        .phase               (phase),
        .pfb_rden            (pfb_rden),
        .execute             (ce0_execute),
        .input_row           (input_row),
        .input_col           (input_col),
        .num_cols            (num_cols),
        .pixel_datain        (ce0_pixel_datain),
        .even_addr           (even_addr),
        .odd_addr            (odd_addr),
        .pixel_dataout       (ce0_pixel_dataout),
        .pixel_dataout_valid (ce0_pixel_dataout_valid),
        .cycle_counter       (ce0_cycle_counter)
    );

    ce_row_buffer u_ce1 (
        .clk                 (clk),
        .rst                 (rst),
        .phase               (phase),
        .pfb_rden            (pfb_rden),
        .execute             (ce1_execute),
        .input_row           (input_row),
        .input_col           (input_col),
        .num_cols            (num_cols),
        .pixel_datain        (ce1_pixel_datain),
        .even_addr           (even_addr_d),
        .odd_addr            (odd_addr_d),
        .pixel_dataout       (ce1_pixel_dataout),
        .pixel_dataout_valid (ce1_pixel_dataout_valid),
        .cycle_counter       (ce1_cycle_counter)
    );

endmodule

//--- design/ce_row_buffer.sv
`timescale 1ns/1ns
`include "awe_config.svh"

module ce_row_buffer (
    input  logic                       clk,
    input  logic                       rst,
    input  awe_ctrl_pkg::awe_phase_t   phase,
    input  logic                       pfb_rden,
    input  logic                       execute,
    input  awe_data_pkg::row_idx_t     input_row,
    input  awe_data_pkg::col_idx_t     input_col,
    input  awe_data_pkg::col_idx_t     num_cols,
    input  awe_data_pkg::pixel_t       pixel_datain,
    input  awe_data_pkg::bank_addr_t   even_addr,
    input  awe_data_pkg::bank_addr_t   odd_addr,
    output awe_data_pkg::pixel_pair_t  pixel_dataout,
    output logic                       pixel_dataout_valid,
    output awe_ctrl_pkg::window_cnt_t  cycle_counter
);
    import awe_data_pkg::*;
    import awe_ctrl_pkg::*;

    logic       prime_hit;
    logic       even_wren;
    logic       odd_wren;
    bank_addr_t even_wr_addr;
    bank_addr_t odd_wr_addr;
    pixel_t     wr_data;
    logic       rden;
    bank_addr_t even_rd_addr;
    bank_addr_t odd_rd_addr;
    pixel_t     even_rd_data;
    pixel_t     odd_rd_data;

    //////////////////////////////////////////////////////////////////////
    // priming writes
    //////////////////////////////////////////////////////////////////////

    assign prime_hit = (phase == prim_buffer) && pfb_rden && (input_col <= num_cols);

    // row 0 goes to both halves 0, row 1 odd half 1, row 2 even half 1
    always_ff @(posedge clk) begin
        if (rst) begin
            even_wren <= 1'b0;
            odd_wren <= 1'b0;
        end else begin
            even_wren <= prime_hit && (input_row == 2'd0 || input_row == 2'd2);
            odd_wren <= prime_hit && (input_row == 2'd0 || input_row == 2'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (pfb_rden) begin
            wr_data <= pixel_datain;
            even_wr_addr <= {input_row == 2'd2, input_col};
            odd_wr_addr <= {input_row == 2'd1, input_col};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // execute reads
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rden <= 1'b0;
        end else begin
            rden <= (phase == ce_active) && execute;
        end
    end

    always_ff @(posedge clk) begin
        if (execute) begin
            even_rd_addr <= even_addr;
            odd_rd_addr <= odd_addr;
        end
    end

    row_buffer_ram u_even_bank (
        .clk     (clk),
        .wren    (even_wren),
        .wr_addr (even_wr_addr),
        .wr_data (wr_data),
        .rden    (rden),
        .rd_addr (even_rd_addr),
        .rd_data (even_rd_data)
    );

    row_buffer_ram u_odd_bank (
        .clk     (clk),
        .wren    (odd_wren),
        .wr_addr (odd_wr_addr),
        .wr_data (wr_data),
        .rden    (rden),
        .rd_addr (odd_rd_addr),
        .rd_data (odd_rd_data)
    );

    // one more stage lines the pair up with valid during bursts
    always_ff @(posedge clk) begin
        pixel_dataout <= {odd_rd_data, even_rd_data};
    end

    strobe_delay #(
        .cycles (`AWE_VALID_DELAY)
    ) u_valid_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (rden),
        .dout (pixel_dataout_valid)
    );

    // window position, restarts whenever the valid stream breaks
    always_ff @(posedge clk) begin
        if (rst || !pixel_dataout_valid) begin
            cycle_counter <= '0;
        end else if (cycle_counter == window_cnt_t'(`AWE_WINDOW_CYCLES - 1)) begin
            cycle_counter <= '0;
        end else begin
            cycle_counter <= cycle_counter + 1'b1;
        end
    end

endmodule

//--- design/pix_seq_decoder.sv
`timescale 1ns/1ns

module pix_seq_decoder (
    input  logic                     clk,
    input  logic                     rst,
    input  awe_data_pkg::seq_word_t  seq_datain,
    input  awe_ctrl_pkg::gray_code_t gray_code,
    output awe_data_pkg::bank_addr_t even_addr,
    output awe_data_pkg::bank_addr_t odd_addr,
    output awe_data_pkg::bank_addr_t even_addr_d,
    output awe_data_pkg::bank_addr_t odd_addr_d
);
    import awe_data_pkg::*;

    logic     flip;
    col_idx_t even_col;
    col_idx_t odd_col;

    //////////////////////////////////////////////////////////////////////
    // field split
    //////////////////////////////////////////////////////////////////////

    assign flip = seq_datain[seq_flip_bit];
    assign odd_col = seq_datain[seq_flip_bit-1:seq_odd_lsb];
    assign even_col = seq_datain[seq_odd_lsb-1:0];

    // half bit picks which stored row the window reads
    assign even_addr = {gray_code[1] ^ flip, even_col};
    assign odd_addr = {gray_code[0] ^ flip, odd_col};

    //////////////////////////////////////////////////////////////////////
    // engine 1 starts a cycle later
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            even_addr_d <= '0;
            odd_addr_d <= '0;
        end else begin
            even_addr_d <= even_addr;
            odd_addr_d <= odd_addr;
        end
    end

endmodule

//--- design/row_buffer_ram.sv
`timescale 1ns/1ns
`include "awe_config.svh"

module row_buffer_ram (
    input  logic                     clk,
    input  logic                     wren,
    input  awe_data_pkg::bank_addr_t wr_addr,
    input  awe_data_pkg::pixel_t     wr_data,
    input  logic                     rden,
    input  awe_data_pkg::bank_addr_t rd_addr,
    output awe_data_pkg::pixel_t     rd_data
);
    import awe_data_pkg::*;

    localparam int depth = 2 ** $bits(bank_addr_t);
    localparam int out_stages = `AWE_RAM_READ_LATENCY - 1;

    pixel_t mem [depth];
    pixel_t rd_q;
    pixel_t out_pipe [out_stages];

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // array read only on rden, so the output holds between reads
    always_ff @(posedge clk) begin
        if (rden) begin
            rd_q <= mem[rd_addr];
        end
        out_pipe[0] <= rd_q;
        for (int i = 1; i < out_stages; i++) begin
            out_pipe[i] <= out_pipe[i-1];
        end
    end

    assign rd_data = out_pipe[out_stages-1];

endmodule

//--- design/strobe_delay.sv
`timescale 1ns/1ns

module strobe_delay #(
    parameter int cycles = 3
) (
    input  logic clk,
    input  logic rst,
    input  logic din,
    output logic dout
);

    if (cycles == 0) begin : g_pass
        assign dout = din;
    end else begin : g_shift
        logic [cycles-1:0] sr;

        always_ff @(posedge clk) begin
            if (rst) begin
                sr <= '0;
            end else begin
                sr[0] <= din;
                for (int i = 1; i < cycles; i++) begin
                    sr[i] <= sr[i-1];
                end
            end
        end

        assign dout = sr[cycles-1];
    end

endmodule

//--- list.f
+incdir+design
design/awe_ctrl_pkg.sv
design/awe_data_pkg.sv
design/row_buffer_ram.sv
design/strobe_delay.sv
design/pix_seq_decoder.sv
design/ce_row_buffer.sv
design/awe_row_buffers.sv
tests/awe_row_buffers_assertions.sv
tests/awe_row_buffers_tb.sv

//--- tests/awe_row_buffers_assertions.sv
`timescale 1ns/1ns
`include "awe_config.svh"

module awe_row_buffers_assertions (
    input logic                      clk,
    input logic                      rst,
    input awe_ctrl_pkg::awe_phase_t  phase,
    input logic                      ce0_execute,
    input logic                      ce1_execute,
    input logic                      ce0_pixel_dataout_valid,
    input logic                      ce1_pixel_dataout_valid,
    input awe_ctrl_pkg::window_cnt_t ce0_cycle_counter,
    input awe_ctrl_pkg::window_cnt_t ce1_cycle_counter
);
    import awe_ctrl_pkg::*;

    // execute edge to the cycle where valid is seen high
    localparam int read_to_valid = `AWE_VALID_DELAY + 1;

    int   fail_count;
    logic ce0_read;
    logic ce1_read;
    // valid cycles in a row before the current one
    int   ce0_run;
    int   ce1_run;

    initial fail_count = 0;

    assign ce0_read = (phase == ce_active) && ce0_execute;
    assign ce1_read = (phase == ce_active) && ce1_execute;

    always @(posedge clk) begin
        if (rst || !ce0_pixel_dataout_valid) begin
            ce0_run <= 0;
        end else begin
            ce0_run <= ce0_run + 1;
        end
    end

    always @(posedge clk) begin
        if (rst || !ce1_pixel_dataout_valid) begin
            ce1_run <= 0;
        end else begin
            ce1_run <= ce1_run + 1;
        end
    end

    reset_quiet: assert property (@(posedge clk)
        rst |=> !ce0_pixel_dataout_valid && !ce1_pixel_dataout_valid
            && ce0_cycle_counter == '0 && ce1_cycle_counter == '0)
    else begin
        $error("valid or window counter not cleared by reset");
        fail_count++;
    end

    //////////////////////////////////////////////////////////////////////
    // fixed read latency and one valid per execute
    //////////////////////////////////////////////////////////////////////

    ce0_latency: assert property (@(posedge clk) disable iff (rst)
        ce0_pixel_dataout_valid == $past(ce0_read, read_to_valid))
    else begin
        $error("ce0 valid does not follow its execute by the read latency");
        fail_count++;
    end

    ce1_latency: assert property (@(posedge clk) disable iff (rst)
        ce1_pixel_dataout_valid == $past(ce1_read, read_to_valid))
    else begin
        $error("ce1 valid does not follow its execute by the read latency");
        fail_count++;
    end

    //////////////////////////////////////////////////////////////////////
    // window counter against the length of the valid run
    //////////////////////////////////////////////////////////////////////

    ce0_window: assert property (@(posedge clk) disable iff (rst)
        ce0_cycle_counter == window_cnt_t'(ce0_run % `AWE_WINDOW_CYCLES))
    else begin
        $error("ce0 window counter out of step with valid");
        fail_count++;
    end

    ce1_window: assert property (@(posedge clk) disable iff (rst)
        ce1_cycle_counter == window_cnt_t'(ce1_run % `AWE_WINDOW_CYCLES))
    else begin
        $error("ce1 window counter out of step with valid");
        fail_count++;
    end

endmodule

bind awe_row_buffers awe_row_buffers_assertions u_assertions (
    .clk                     (clk),
    .rst                     (rst),
    .phase                   (phase),
    .ce0_execute             (ce0_execute),
    .ce1_execute             (ce1_execute),
    .ce0_pixel_dataout_valid (ce0_pixel_dataout_valid),
    .ce1_pixel_dataout_valid (ce1_pixel_dataout_valid),
    .ce0_cycle_counter       (ce0_cycle_counter),
    .ce1_cycle_counter       (ce1_cycle_counter)
);

//--- tests/awe_row_buffers_tb.sv
`timescale 1ns/1ns

module awe_row_buffers_tb;
    import awe_data_pkg::*;
    import awe_ctrl_pkg::*;

    // about 400 cycles of tests, with margin
    localparam int max_cycles = 2000;

    logic        clk;
    logic        rst;
    awe_phase_t  phase;
    gray_code_t  gray_code;
    logic        pfb_rden;
    row_idx_t    input_row;
    col_idx_t    input_col;
    col_idx_t    num_cols;
    seq_word_t   seq_datain;
    pixel_t      ce0_pixel_datain;
    pixel_t      ce1_pixel_datain;
    logic        ce0_execute;
    logic        ce1_execute;
    pixel_pair_t ce0_pixel_dataout;
    logic        ce0_pixel_dataout_valid;
    window_cnt_t ce0_cycle_counter;
    pixel_pair_t ce1_pixel_dataout;
    logic        ce1_pixel_dataout_valid;
    window_cnt_t ce1_cycle_counter;

    integer      seed;
    int          errors;
    int          cycles;
    pixel_t      even_model [2][64];
    pixel_t      odd_model [2][64];
    pixel_pair_t ce0_expected [$];
    pixel_pair_t ce1_expected [$];
    logic [11:0] last_addrs;

    awe_row_buffers u_awe_row_buffers (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // odd address above even address, half bits flipped by gray code and flip bit
    function automatic logic [11:0] decode_word(input seq_word_t word, input gray_code_t gray);
        bank_addr_t even_a;
        bank_addr_t odd_a;
        even_a = {gray[1] ^ word[10], word[4:0]};
        odd_a = {gray[0] ^ word[10], word[9:5]};
        return {odd_a, even_a};
    endfunction

    task automatic model_write(input int ce, input pixel_t pix);
        case (input_row)
            2'd0: begin
                even_model[ce][{1'b0, input_col}] = pix;
                odd_model[ce][{1'b0, input_col}] = pix;
            end
            2'd1: odd_model[ce][{1'b1, input_col}] = pix;
            2'd2: even_model[ce][{1'b1, input_col}] = pix;
            default: ;
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model, sampled on the rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        logic [11:0] addrs;
        addrs = decode_word(seq_datain, gray_code);
        if (rst) begin
            last_addrs = '0;
        end else begin
            if (phase == prim_buffer && pfb_rden && input_col <= num_cols) begin
                model_write(0, ce0_pixel_datain);
                model_write(1, ce1_pixel_datain);
            end
            if (phase == ce_active && ce0_execute) begin
                ce0_expected.push_back({odd_model[0][addrs[11:6]], even_model[0][addrs[5:0]]});
            end
            // engine 1 reads with last cycle's word
            if (phase == ce_active && ce1_execute) begin
                ce1_expected.push_back({odd_model[1][last_addrs[11:6]],
                                        even_model[1][last_addrs[5:0]]});
            end
            last_addrs = addrs;
        end
    end

    task automatic check_pair(input int ce, input pixel_pair_t got);
        pixel_pair_t exp;
        if ((ce == 0 && ce0_expected.size() == 0) || (ce == 1 && ce1_expected.size() == 0)) begin
            $display("ce%0d raised valid with no read outstanding", ce);
            errors++;
        end else begin
            if (ce == 0) begin
                exp = ce0_expected.pop_front();
            end else begin
                exp = ce1_expected.pop_front();
            end
            assert (got === exp) else begin
                $display("FAIL ce%0d_pixel_dataout got %h expected %h", ce, got, exp);
                errors++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst && ce0_pixel_dataout_valid) begin
            check_pair(0, ce0_pixel_dataout);
        end
        if (!rst && ce1_pixel_dataout_valid) begin
            check_pair(1, ce1_pixel_dataout);
        end
    end

    task automatic expect_zero(input string name, input logic [2:0] value);
        assert (value === 3'd0) else begin
            $display("FAIL %s got %h expected 0", name, value);
            errors++;
        end
    endtask

    task automatic check_quiet();
        expect_zero("ce0_pixel_dataout_valid", {2'b00, ce0_pixel_dataout_valid});
        expect_zero("ce1_pixel_dataout_valid", {2'b00, ce1_pixel_dataout_valid});
        expect_zero("ce0_cycle_counter", ce0_cycle_counter);
        expect_zero("ce1_cycle_counter", ce1_cycle_counter);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus, driven on the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic prime(input row_idx_t row, input col_idx_t col);
        pfb_rden = 1'b1;
        input_row = row;
        input_col = col;
        ce0_pixel_datain = pixel_t'($random(seed));
        ce1_pixel_datain = pixel_t'($random(seed));
        @(negedge clk);
    endtask

    task automatic prime_rows(input int rows);
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < 32; c++) begin
                prime(row_idx_t'(r), col_idx_t'(c));
            end
        end
        pfb_rden = 1'b0;
        @(negedge clk);
    endtask

    task automatic stray_primes(input int count);
        for (int i = 0; i < count; i++) begin
            prime(row_idx_t'($random(seed)), col_idx_t'($random(seed)));
        end
        pfb_rden = 1'b0;
        @(negedge clk);
    endtask

    // engine 1 trails engine 0 by one cycle when both run
    task automatic read_burst(input gray_code_t gray, input bit set_flip, input int len,
                              input bit both);
        seq_word_t word;
        gray_code = gray;
        for (int i = 0; i <= len; i++) begin
            word = seq_word_t'($random(seed));
            if (set_flip) begin
                word[10] = 1'b1;
            end
            seq_datain = word;
            ce1_execute = both && ce0_execute;
            ce0_execute = (i < len);
            @(negedge clk);
        end
        ce1_execute = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        seed = 32'h5582;
        errors = 0;
        cycles = 0;
        rst = 1'b1;
        phase = idle;
        gray_code = 2'b00;
        pfb_rden = 1'b0;
        input_row = '0;
        input_col = '0;
        num_cols = '0;
        seq_datain = '0;
        ce0_pixel_datain = '0;
        ce1_pixel_datain = '0;
        ce0_execute = 1'b0;
        ce1_execute = 1'b0;

        repeat (10) begin
            @(negedge clk);
            check_quiet();
        end
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_quiet();
        end

        // full rows first, then a short pass where the tail and row 3 must not land
        phase = prim_buffer;
        num_cols = 5'd31;
        prime_rows(3);
        num_cols = col_idx_t'(8 + ($random(seed) & 15));
        prime_rows(4);

        phase = wait_pfb_load;
        stray_primes(16);
        phase = idle;
        stray_primes(16);
        phase = ce_active;
        stray_primes(8);

        // engine 0 alone on gray code 00
        for (int len = 1; len <= 7; len++) begin
            read_burst(2'b00, 1'b0, len, 1'b0);
        end
        for (int g = 1; g < 4; g++) begin
            read_burst(gray_code_t'(g), 1'b1, 7, 1'b1);
            read_burst(gray_code_t'(g), 1'b0, 6, 1'b1);
        end

        phase = wait_job_done;
        repeat (10) @(negedge clk);
        if (ce0_expected.size() != 0 || ce1_expected.size() != 0) begin
            $display("reads never answered by valid, %0d on ce0 and %0d on ce1",
                     ce0_expected.size(), ce1_expected.size());
            errors++;
        end
        $display("data errors %0d, assertion errors %0d", errors,
                 u_awe_row_buffers.u_assertions.fail_count);
        if (errors == 0 && u_awe_row_buffers.u_assertions.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
